/* logic/uart_pkg.sv */
package uart_pkg;

	// bit timing at 50 MHz system clock
	localparam int BIT_CLKS  = 25; // 50 MHz / 2 Mbit/s
	localparam int MID_CLK   = 12; // sample point inside a bit
	localparam int DATA_BITS = 8;  // 8N1 frame, no parity

	typedef logic [DATA_BITS-1:0] uart_byte_t; // one payload byte
	typedef logic [4:0]           clk_cnt_t;   // counts 0..BIT_CLKS-1
	typedef logic [3:0]           bit_idx_t;   // 0 start, 1..8 data, 9 stop

	// what the receiver hands out per frame
	typedef struct packed {
		uart_byte_t data;      // lsb arrived first
		logic       frame_err; // stop bit sampled low
	} rx_frame_t;

	typedef enum logic {
		TX_IDLE, // line high, ready for a byte
		TX_BUSY  // shifting a frame out
	} tx_state_t;

	typedef enum logic [1:0] {
		RX_IDLE,     // waiting for a falling edge
		RX_START,    // checking start bit at mid-bit
		RX_DATA_STOP // data bits then stop bit
	} rx_state_t;

endpackage

/* logic/uart_send_hs.sv */
`timescale 1ns/1ps

module uart_send_hs import uart_pkg::*; (
	input  logic       sys_clk,  // system clock
	input  logic       rst,      // sync reset, active high
	input  logic       tx_valid, // source offers a byte
	output logic       tx_ready, // high only when idle
	input  uart_byte_t tx_data,  // byte to send, held until taken
	output logic       uart_txd  // serial line out
);

	tx_state_t  state;     // fsm state
	clk_cnt_t   clk_cnt;   // clocks into the current bit
	bit_idx_t   bit_idx;   // position in the frame
	uart_byte_t shreg;     // data still to go, lsb next
	logic       txd_q;     // line driver flop
	logic       accept;    // handshake on this edge
	logic       bit_end;   // last clock of a bit
	logic       frame_end; // last clock of the stop bit

	assign tx_ready  = (state == TX_IDLE);
	assign accept    = tx_valid & tx_ready;
	assign bit_end   = (clk_cnt == clk_cnt_t'(BIT_CLKS - 1));
	assign frame_end = bit_end && (bit_idx == bit_idx_t'(DATA_BITS + 1));
	assign uart_txd  = txd_q; // straight from a flop, no glitches on the pin

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			state   <= TX_IDLE;
			clk_cnt <= '0;
			bit_idx <= '0;
			txd_q   <= 1'b1; // line idles high
		end else begin
			case (state)
				TX_IDLE: begin
					clk_cnt <= '0;
					bit_idx <= '0;
					txd_q   <= 1'b1;
					if (accept) begin
						state <= TX_BUSY;
						txd_q <= 1'b0; // start bit on the next cycle
					end
				end
				TX_BUSY: begin
					if (bit_end) begin
						clk_cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						txd_q   <= shreg[0]; // next data bit, ones once drained
						if (frame_end) begin
							// stop bit done, back to idle
							state   <= TX_IDLE;
							bit_idx <= '0;
							txd_q   <= 1'b1;
						end
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: begin
					state <= TX_IDLE;
					txd_q <= 1'b1;
				end
			endcase
		end
	end

	// payload shifter, fills with ones so bit 9 comes out as the stop bit
	always_ff @(posedge sys_clk) begin
		if (accept) begin
			shreg <= tx_data; // latch on handshake
		end else if (state == TX_BUSY && bit_end) begin
			shreg <= {1'b1, shreg[DATA_BITS-1:1]}; // lsb first
		end
	end

	// a taken byte keeps ready low for exactly one frame
	a_ready_frame: assert property (@(posedge sys_clk) disable iff (rst)
		accept |=> !tx_ready [*(DATA_BITS + 2) * BIT_CLKS] ##1 tx_ready)
		else $error("tx_ready not low for one whole frame");

	a_idle_high: assert property (@(posedge sys_clk) disable iff (rst)
		(state == TX_IDLE) |-> uart_txd)
		else $error("uart_txd low while idle");

endmodule

/* logic/uart_recv_hs.sv */
`timescale 1ns/1ps

module uart_recv_hs import uart_pkg::*; (
	input  logic      sys_clk,  // system clock
	input  logic      rst,      // sync reset, active high
	input  logic      uart_rxd, // async serial line in
	output logic      rx_valid, // one-cycle pulse per frame
	output rx_frame_t rx_frame  // valid only with rx_valid
);

	rx_state_t  state;    // fsm state
	clk_cnt_t   clk_cnt;  // clocks since the detected edge / bit start
	bit_idx_t   bit_idx;  // 0 start, 1..8 data, 9 stop
	uart_byte_t shreg;    // data collected so far
	logic       rxd_meta; // first sync stage
	logic       rxd_sync; // second sync stage, safe to use
	logic       rxd_prev; // for edge detect
	logic       fall;     // high to low on the synced line
	logic       mid_bit;  // sample point reached
	logic       bit_end;  // last clock of a bit
	logic       stop_bit; // currently in the stop bit

	assign fall     = rxd_prev & ~rxd_sync;
	assign mid_bit  = (clk_cnt == clk_cnt_t'(MID_CLK));
	assign bit_end  = (clk_cnt == clk_cnt_t'(BIT_CLKS - 1));
	assign stop_bit = (bit_idx == bit_idx_t'(DATA_BITS + 1));

	// two-flop synchronizer plus one more for the edge
	always_ff @(posedge sys_clk) begin
		if (rst) begin
			rxd_meta <= 1'b1; // assume idle line, no false start
			rxd_sync <= 1'b1;
			rxd_prev <= 1'b1;
		end else begin
			rxd_meta <= uart_rxd;
			rxd_sync <= rxd_meta;
			rxd_prev <= rxd_sync;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			state    <= RX_IDLE;
			clk_cnt  <= '0;
			bit_idx  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0; // pulse only
			case (state)
				RX_IDLE: begin
					clk_cnt <= '0;
					bit_idx <= '0;
					if (fall) begin
						state <= RX_START; // possible start bit
					end
				end
				RX_START: begin
					if (mid_bit && rxd_sync) begin
						state <= RX_IDLE; // glitch, line already back high
					end else if (bit_end) begin
						state   <= RX_DATA_STOP;
						clk_cnt <= '0;
						bit_idx <= bit_idx_t'(1); // first data bit
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				RX_DATA_STOP: begin
					if (mid_bit && stop_bit) begin
						// leave at mid-stop so the next start edge is not missed
						state    <= RX_IDLE;
						rx_valid <= 1'b1;
					end else if (bit_end) begin
						clk_cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: begin
					state <= RX_IDLE;
				end
			endcase
		end
	end

	// mid-bit sampling and frame capture
	always_ff @(posedge sys_clk) begin
		if (state == RX_DATA_STOP && mid_bit) begin
			if (stop_bit) begin
				rx_frame.data      <= shreg;
				rx_frame.frame_err <= ~rxd_sync; // stop must be high
			end else begin
				shreg <= {rxd_sync, shreg[DATA_BITS-1:1]}; // lsb arrives first
			end
		end
	end

	// one frame can never produce two strobes
	a_valid_pulse: assert property (@(posedge sys_clk) disable iff (rst)
		rx_valid |=> !rx_valid)
		else $error("rx_valid high on two cycles in a row");

endmodule

/* logic/uart_hs.sv */
`timescale 1ns/1ps

module uart_hs import uart_pkg::*; (
	input  logic       sys_clk,  // 50 MHz system clock
	input  logic       rst,      // sync reset, active high

	input  logic       uart_rxd, // serial in
	output logic       uart_txd, // serial out

	input  logic       tx_valid, // tx handshake
	output logic       tx_ready,
	input  uart_byte_t tx_data,

	output logic       rx_valid, // rx strobe, no back-pressure
	output rx_frame_t  rx_frame
);

	// transmit side
	uart_send_hs u_send (
		.sys_clk  (sys_clk),
		.rst      (rst),
		.tx_valid (tx_valid),
		.tx_ready (tx_ready),
		.tx_data  (tx_data),
		.uart_txd (uart_txd)
	);

	// receive side
	uart_recv_hs u_recv (
		.sys_clk  (sys_clk),
		.rst      (rst),
		.uart_rxd (uart_rxd),
		.rx_valid (rx_valid),
		.rx_frame (rx_frame)
	);

endmodule

/* dv/uart_hs_tests.svh */
// line idle, ready up, nothing on rx
task automatic idle_after_reset();
	int pulses;
	loop_sel = 1'b1;
	check_value(32'(uart_txd), 32'd1, "uart_txd after reset");
	check_value(32'(tx_ready), 32'd1, "tx_ready after reset");
	pulses = 0;
	repeat (300) begin
		@(negedge sys_clk);
		if (rx_valid) pulses++; // idle line must stay quiet
	end
	check_value(32'(pulses), 32'd0, "rx_valid pulses during idle wait");
	check_value(32'(uart_txd), 32'd1, "uart_txd after idle wait");
endtask

// one byte out and back, ready low for exactly one frame
task automatic single_loopback();
	rx_frame_t f;
	logic      got;
	int        low_cnt;
	loop_sel = 1'b1;
	send_byte(8'hA5, 1'b0);
	check_value(32'(tx_ready), 32'd0, "tx_ready right after acceptance");
	low_cnt = 0;
	fork
		begin
			wait_frame(f, got);
		end
		begin
			// counts falling edges with ready low, from the handshake on
			while (!tx_ready && low_cnt < 2 * frame_cycles()) begin
				low_cnt++;
				@(negedge sys_clk);
			end
		end
	join
	if (got) begin
		check_value(32'(f.data), 32'h0000_00A5, "loopback data");
		check_value(32'(f.frame_err), 32'd0, "loopback frame_err");
	end
	check_value(32'(low_cnt), 32'(frame_cycles()), "clocks with tx_ready low");
	check_value(32'(tx_ready), 32'd1, "tx_ready after the frame");
endtask

// valid held high across three bytes
task automatic back_to_back_burst();
	uart_byte_t bytes [3];
	int         accepts [3];
	rx_frame_t  f;
	logic       got;
	bytes    = '{8'h12, 8'hED, 8'h7E};
	loop_sel = 1'b1;
	fork
		begin
			for (int i = 0; i < 3; i++) begin
				send_byte(bytes[i], (i < 2)); // drop valid after the last one
				accepts[i] = accept_cycle;
			end
		end
		begin
			for (int i = 0; i < 3; i++) begin
				wait_frame(f, got);
				if (got) begin
					check_value(32'(f.data), 32'(bytes[i]), "back-to-back data");
					check_value(32'(f.frame_err), 32'd0, "back-to-back frame_err");
				end
			end
		end
	join
	for (int i = 1; i < 3; i++) begin
		// next handshake no earlier than one frame later
		check_value(32'((accepts[i] - accepts[i-1]) >= frame_cycles()), 32'd1,
			"spacing between accepted bytes");
	end
endtask

// low stop bit from the tb line, then a clean frame
task automatic framing_error_frame();
	rx_frame_t f;
	logic      got;
	loop_sel = 1'b0;
	fork
		send_line_frame(8'h3C, 1'b0);
		wait_frame(f, got);
	join
	if (got) begin
		check_value(32'(f.data), 32'h0000_003C, "framing error data");
		check_value(32'(f.frame_err), 32'd1, "framing error flag");
	end
	repeat (BIT_CLKS) @(negedge sys_clk); // one idle bit
	fork
		send_line_frame(8'hC3, 1'b1);
		wait_frame(f, got);
	join
	if (got) begin
		check_value(32'(f.data), 32'h0000_00C3, "data after framing error");
		check_value(32'(f.frame_err), 32'd0, "frame_err after framing error");
	end
	loop_sel = 1'b1;
endtask

// short low pulse, gone before mid-bit
task automatic glitch_rejection();
	rx_frame_t f;
	logic      got;
	loop_sel = 1'b0;
	@(negedge sys_clk);
	line_q = 1'b0;
	repeat (4) @(negedge sys_clk);
	line_q = 1'b1;
	expect_no_frame(2 * frame_cycles(), "rx_valid pulses after a glitch");
	fork
		send_line_frame(8'h5A, 1'b1);
		wait_frame(f, got);
	join
	if (got) begin
		check_value(32'(f.data), 32'h0000_005A, "data after glitch");
		check_value(32'(f.frame_err), 32'd0, "frame_err after glitch");
	end
	loop_sel = 1'b1;
endtask

// xorshift bytes through the loopback
task automatic random_loopback();
	rx_frame_t  f;
	logic       got;
	uart_byte_t b;
	loop_sel = 1'b1;
	for (int i = 0; i < 20; i++) begin
		rng_state = xorshift32(rng_state);
		b         = rng_state[7:0]; // low byte of the new state
		send_byte(b, 1'b0);
		wait_frame(f, got);
		if (got) begin
			check_value(32'(f.data), 32'(b), "random loopback data");
			check_value(32'(f.frame_err), 32'd0, "random loopback frame_err");
		end
	end
endtask

/* dv/uart_hs_tb.sv */
`timescale 1ns/1ps

module uart_hs_tb import uart_pkg::*; ();

	logic        sys_clk;
	logic        rst;
	logic        tx_valid;
	uart_byte_t  tx_data;
	logic        tx_ready;
	logic        uart_txd;
	logic        rx_valid;
	rx_frame_t   rx_frame;
	logic        loop_sel;        // 1 txd looped to rxd, 0 tb line driver
	logic        line_q;          // tb-driven serial line
	logic        rxd;             // whatever reaches the receiver
	int          errors;
	int          checks;
	int          cycle = 0;       // rising edges since time zero
	int          accept_cycle;    // edge count of the last tx handshake
	logic [31:0] rng_state;

	assign rxd = loop_sel ? uart_txd : line_q;

	uart_hs dut0 (
		.sys_clk  (sys_clk),
		.rst      (rst),
		.uart_rxd (rxd),
		.uart_txd (uart_txd),
		.tx_valid (tx_valid),
		.tx_ready (tx_ready),
		.tx_data  (tx_data),
		.rx_valid (rx_valid),
		.rx_frame (rx_frame)
	);

	always #4 sys_clk = ~sys_clk; // 125 MHz sim clock, 8 ns period

	always @(posedge sys_clk) begin
		cycle <= cycle + 1;
	end

	// start + data + stop, in clocks
	function automatic int frame_cycles();
		return (DATA_BITS + 2) * BIT_CLKS;
	endfunction

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("failure at %0t ns: %s", $time, what);
	endtask

	// offer a byte, return on the falling edge right after the handshake
	task automatic send_byte(input uart_byte_t b, input logic hold);
		int n;
		@(negedge sys_clk);
		tx_valid = 1'b1;
		tx_data  = b;
		n = 0;
		while (!tx_ready && n < 2 * frame_cycles()) begin
			@(negedge sys_clk); // back-pressure, keep offering
			n++;
		end
		if (!tx_ready) begin
			report_failure("tx_ready stayed low, byte was never accepted");
			tx_valid = 1'b0;
		end else begin
			@(negedge sys_clk); // taken on the rising edge just passed
			accept_cycle = cycle;
			tx_valid = hold; // leave high for back-to-back
		end
	endtask

	// one 8N1 frame on the tb line, stop level selectable
	task automatic send_line_frame(input uart_byte_t b, input logic stop);
		@(negedge sys_clk);
		line_q = 1'b0; // start
		repeat (BIT_CLKS) @(negedge sys_clk);
		for (int i = 0; i < DATA_BITS; i++) begin
			line_q = b[i]; // lsb first
			repeat (BIT_CLKS) @(negedge sys_clk);
		end
		line_q = stop;
		repeat (BIT_CLKS) @(negedge sys_clk);
		line_q = 1'b1; // back to idle
	endtask

	// wait for the rx strobe, two frame times at most
	task automatic wait_frame(output rx_frame_t f, output logic got);
		int n;
		got = 1'b0;
		f   = '0;
		n   = 0;
		while (!got && n < 2 * frame_cycles()) begin
			@(negedge sys_clk);
			if (rx_valid) begin
				got = 1'b1;
				f   = rx_frame; // only valid this cycle
			end
			n++;
		end
		if (!got) begin
			report_failure("no frame received");
		end
	endtask

	task automatic expect_no_frame(input int n_cycles, input string what);
		int seen;
		seen = 0;
		repeat (n_cycles) begin
			@(negedge sys_clk);
			if (rx_valid) seen++;
		end
		check_value(32'(seen), 32'd0, what);
	endtask

	`include "uart_hs_tests.svh"

	// 32 frame slots covers all frames plus idle waits, x3 margin
	initial begin
		#(32 * 10 * BIT_CLKS * 8 * 3);
		$display("watchdog expired, the tests did not finish in time");
		$display("sim failed");
		$finish;
	end

	initial begin
		sys_clk   = 1'b0;
		rst       = 1'b1;
		tx_valid  = 1'b0;
		tx_data   = '0;
		loop_sel  = 1'b1;
		line_q    = 1'b1; // idle high
		errors    = 0;
		checks    = 0;
		rng_state = 32'h72d89dcb;
		repeat (2) @(posedge sys_clk);
		@(negedge sys_clk);
		rst = 1'b0;
		idle_after_reset();
		single_loopback();
		back_to_back_burst();
		framing_error_frame();
		glitch_rejection();
		random_loopback();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

/* all.f */
+incdir+dv
logic/uart_pkg.sv
logic/uart_send_hs.sv
logic/uart_recv_hs.sv
logic/uart_hs.sv
dv/uart_hs_tb.sv

/* run.sh */
#!/bin/sh
# build and run the uart testbench, verdict from the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module uart_hs_tb -f all.f -o uart_hs_sim \
	&& ./obj_dir/uart_hs_sim > sim.log 2>&1

cat sim.log 2>/dev/null
grep -qx "sim passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
